// File: filelist.f
+incdir+hdl
hdl/robots_pkg.sv
hdl/command_decode.sv
hdl/prng_pair.sv
hdl/field_scan.sv
hdl/bcd_counter.sv
hdl/score_keeper.sv
hdl/robots_play_top.sv
verif/tile_map_model.sv
verif/robots_play_tb.sv

// File: hdl/bcd_counter.sv
// decimal counter, wraps from all nines to zero; clear wins over inc in the same cycle
module bcd_counter #(
    parameter int DIGITS = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  inc,
    output logic [DIGITS*4-1:0]   value,
    output logic [DIGITS-1:0]     blank   // leading zeros to hide
);

    logic [DIGITS*4-1:0] value_next;

    // ripple carry through the digits
    always_comb begin
        logic carry;
        carry      = 1'b1;
        value_next = value;
        for (int i = 0; i < DIGITS; i++) begin
            if (carry) begin
                if (value[i*4 +: 4] == 4'd9) begin
                    value_next[i*4 +: 4] = 4'd0; // carry on up
                end else begin
                    value_next[i*4 +: 4] = value[i*4 +: 4] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear)
            value <= '0;
        else if (inc)
            value <= value_next;
    end

    // a digit is blank when it and all above are zero; units always shown
    always_comb begin
        logic zero_run;
        zero_run = 1'b1;
        blank    = '0;
        for (int i = DIGITS - 1; i > 0; i--) begin
            zero_run = zero_run && (value[i*4 +: 4] == 4'd0);
            blank[i] = zero_run;
        end
    end

endmodule

// File: hdl/command_decode.sv
// commands are single-cycle strobes on cmd; a strobe is held until the engine is idle, repeats merge
module command_decode (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] cmd,            // only bits 8-11 are looked at
    input  logic        idle,           // engine can take a new pass
    output logic        go_trash,
    output logic        go_level,
    output logic        go_game,
    output logic        want_attention
);

    logic pend_f1;   // new level
    logic pend_f2;   // beep
    logic pend_f3;   // trash fill, bumps score
    logic pend_quit; // new game

    // fixed priority F3, F1, F2, quit; at most one grant per cycle
    always_comb begin
        go_trash       = idle && pend_f3;
        go_level       = idle && !pend_f3 && pend_f1;
        want_attention = idle && !pend_f3 && !pend_f1 && pend_f2;
        go_game        = idle && !pend_f3 && !pend_f1 && !pend_f2 && pend_quit;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_f1   <= 1'b0;
            pend_f2   <= 1'b0;
            pend_f3   <= 1'b0;
            pend_quit <= 1'b0;
        end else begin
            // a fresh strobe wins over the clear of the same flag
            pend_f1   <= (pend_f1 && !go_level) || cmd[8];
            pend_f2   <= (pend_f2 && !want_attention) || cmd[9];
            pend_f3   <= (pend_f3 && !go_trash) || cmd[10];
            pend_quit <= (pend_quit && !go_game) || cmd[11];
        end
    end

endmodule

// File: hdl/field_scan.sv
// scans the tile map from the last byte to byte 0 at five cycles per byte; go pulses are taken only in IDLE
`include "robots_config.svh"

module field_scan import robots_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       go_trash,
    input  logic       go_level,
    input  logic       go_game,
    input  rand_t      rand_bits,
    input  logic       score_wen,   // digit writer wants this byte
    input  tile_byte_t score_wrt,
    output logic       idle,
    output logic       score_clear,
    output logic       level_inc,
    output logic       score_inc,
    output logic       digit_read,  // tm_red holds a score side byte
    output tile_addr_t tm_adr,
    output tile_byte_t tm_wrt,
    output logic       tm_wen
);

    localparam cell_x_t COL_LAST = cell_x_t'(`MAP_COLS - 1);
    localparam pair_y_t ROW_LAST = pair_y_t'(`MAP_PAIR_ROWS - 1);

    opcode_t     opcode;
    opcode_t     pass_next;        // what follows the running pass
    cell_x_t     scan_x;
    pair_y_t     scan_y;
    scan_phase_t phase;
    logic        last_phase;
    logic        last_byte;
    logic        score_side;       // columns 120-127
    logic        writing;          // pass that updates the map
    logic [10:0] robot_prob;       // per 2^16 cells
    logic [11:0] prob_sum;
    logic        place_robot;
    logic        place_robot_old;  // upper cell decision from phase 0
    cell_x_t     player_x;
    cell_y_t     player_y;
    logic [2:0]  player_band;      // 1-4, sixteen rows each
    logic        player_pair;
    cell_code_t  upper_cell;
    cell_code_t  lower_cell;

    assign last_phase = (phase == `SCAN_LAST_PHASE);
    assign last_byte  = (scan_x == '0) && (scan_y == '0);
    assign score_side = (scan_x[6:3] == `SCORE_COL_MSB);
    assign writing    = (opcode == OP_NEWLEVEL) || (opcode == OP_TRASH);
    assign idle       = (opcode == OP_IDLE);
    assign pass_next  = (opcode == OP_NEWGAME) ? OP_NEWLEVEL : OP_IDLE;

    // result pulses; go_* only arrive while idle
    assign score_clear = (opcode == OP_BOOT) || go_game;
    assign score_inc   = go_trash;
    assign level_inc   = go_level || ((opcode == OP_NEWGAME) && last_byte && (phase == '0));
    assign digit_read  = writing && score_side && (phase == 3'd1); // read of phase 0 is back

    always_ff @(posedge clk) begin
        if (rst) begin
            opcode <= OP_BOOT;
            scan_x <= COL_LAST;
            scan_y <= ROW_LAST;
            phase  <= '0;
        end else begin
            case (opcode)
                OP_IDLE: begin
                    if (go_trash)
                        opcode <= OP_TRASH;
                    else if (go_level)
                        opcode <= OP_NEWLEVEL;
                    else if (go_game)
                        opcode <= OP_NEWGAME;
                end
                OP_BOOT: opcode <= OP_NEWGAME;    // score cleared this cycle
                default: begin
                    if (!last_phase) begin
                        phase <= phase + 3'd1;
                    end else begin
                        phase <= '0;
                        if (scan_x != '0) begin
                            scan_x <= scan_x - 7'd1;
                        end else begin
                            scan_x <= COL_LAST;       // next pair row up
                            if (scan_y != '0) begin
                                scan_y <= scan_y - 6'd1;
                            end else begin
                                scan_y <= ROW_LAST;   // pass done
                                opcode <= pass_next;
                            end
                        end
                    end
                end
            endcase
        end
    end

    // robot density grows each level, held below 2048 so it never wraps to zero
    assign prob_sum = {1'b0, robot_prob} + `ROBOT_PROB_STEP;
    always_ff @(posedge clk) begin
        if (rst || score_clear)
            robot_prob <= '0;
        else if (level_inc && !prob_sum[11])
            robot_prob <= prob_sum[10:0];
    end
    assign place_robot = (rand_bits < {5'd0, robot_prob});

    always_ff @(posedge clk) begin
        if (phase == '0)
            place_robot_old <= place_robot;
    end

    // player spot; columns 120-127 fold back into the play side
    assign player_band = {1'b0, rand_bits[12:11]} + 3'd1;
    always_ff @(posedge clk) begin
        if (level_inc) begin
            player_x <= (rand_bits[6:3] == `SCORE_COL_MSB) ? {1'b0, rand_bits[5:0]}
                                                            : rand_bits[6:0];
            player_y <= {player_band, rand_bits[10:7]};  // rows 16-79
        end
    end
    assign player_pair = (scan_x == player_x) && (scan_y == player_y[6:1]);

    // player beats robot in either cell
    always_comb begin
        if (player_pair && !player_y[0])
            upper_cell = CELL_PLAYER;
        else if (place_robot_old)
            upper_cell = CELL_ROBOT;
        else
            upper_cell = CELL_EMPTY;
        if (player_pair && player_y[0])
            lower_cell = CELL_PLAYER;
        else if (place_robot)
            lower_cell = CELL_ROBOT;
        else
            lower_cell = CELL_EMPTY;
    end

    // tile map port, address held for all five phases
    always_comb begin
        tm_adr = {scan_y, scan_x};
        tm_wrt = '0;
        tm_wen = 1'b0;
        if (writing && score_side) begin
            tm_wen = digit_read && score_wen;  // digits go back in phase 1
            tm_wrt = score_wrt;
        end else if (opcode == OP_NEWLEVEL) begin
            tm_wen = last_phase;
            tm_wrt = {4'd0, lower_cell, upper_cell};
        end else if (opcode == OP_TRASH) begin
            tm_wen = (phase == '0);
            tm_wrt = rand_bits[7:0];            // any cell code, on purpose
        end
    end

endmodule

// File: hdl/prng_pair.sv
// free-running, not cryptographic; two seeds fixed in the config header, restarted by rst
`include "robots_config.svh"

module prng_pair import robots_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output rand_t rand_bits
);

    logic [19:0] lfsr1;
    logic [19:0] lfsr2;

    // three fibonacci steps, taps 20 and 17
    function automatic logic [19:0] step3(input logic [19:0] s);
        logic [19:0] t;
        t = s;
        for (int i = 0; i < 3; i++)
            t = {t[18:0], t[19] ^ t[16]}; // newest bit enters at bit 0
        return t;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr1 <= `PRNG_SEED1;
            lfsr2 <= `PRNG_SEED2;
        end else begin
            lfsr1 <= step3(lfsr1);
            lfsr2 <= step3(lfsr2);
        end
    end

    // interleave low bytes, even bits from lfsr1
    always_comb begin
        for (int g = 0; g < 8; g++) begin
            rand_bits[2*g]   = lfsr1[g];
            rand_bits[2*g+1] = lfsr2[g];
        end
    end

endmodule

// File: hdl/robots_config.svh
// map geometry is fixed at 128 columns by 48 pair rows; tag codes assume the score side sits in columns 120-127
`ifndef ROBOTS_CONFIG_SVH
`define ROBOTS_CONFIG_SVH

// tile map geometry, scanned in reverse
`define MAP_COLS        128      // bytes per pair row
`define MAP_PAIR_ROWS   48       // rows of cell pairs
`define SCAN_LAST_PHASE 3'd4     // five cycles spent on each byte

// column bits [6:3] at this value mark the score side
`define SCORE_COL_MSB   4'd15

// top three bits of a tag byte on the score side
`define TAG_LEVEL       3'd5     // 160, start of level digits
`define TAG_SCORE       3'd6     // 192, start of score digits
`define TAG_HIGH        3'd7     // 224, start of high score digits
`define BLANK_DIGIT     4'd10    // glyph code for a hidden digit

`define ROBOT_PROB_STEP 12'd171  // robots per 2^16 cells, added each level

`define PRNG_SEED1      20'd1
`define PRNG_SEED2      20'h04182 // about half a period away from seed 1

`endif

// File: hdl/robots_pkg.sv
// shared types for the play engine; widths assume the 128 x 48 byte tile map of two cells per byte
package robots_pkg;

    typedef logic [12:0] tile_addr_t;  // {pair row, column}
    typedef logic [7:0]  tile_byte_t;  // one tile map byte
    typedef logic [6:0]  cell_x_t;     // column 0-127
    typedef logic [5:0]  pair_y_t;     // pair row 0-47
    typedef logic [6:0]  cell_y_t;     // cell row 0-95
    typedef logic [2:0]  scan_phase_t; // phase within a byte, 0-4
    typedef logic [15:0] rand_t;       // prng word
    typedef logic [7:0]  bcd2_t;       // two bcd digits
    typedef logic [23:0] bcd6_t;       // six bcd digits

    // pass being run over the tile map
    typedef enum logic [3:0] {
        OP_IDLE     = 4'd0, // waiting for a command
        OP_NEWGAME  = 4'd2, // silent pass, bumps level at the end
        OP_NEWLEVEL = 4'd3, // fresh robots and player
        OP_TRASH    = 4'd6, // fill play area with noise
        OP_BOOT     = 4'd7  // one cycle after reset
    } opcode_t;

    // contents of one play cell, two per byte
    typedef enum logic [1:0] {
        CELL_EMPTY  = 2'd0,
        CELL_ROBOT  = 2'd1,
        CELL_TRASH  = 2'd2,
        CELL_PLAYER = 2'd3
    } cell_code_t;

endpackage

// File: hdl/robots_play_top.sv
// tile map must answer with one cycle read latency; only cmd bits 8-11 do anything
module robots_play_top import robots_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] cmd,
    input  tile_byte_t  tm_red,
    output tile_addr_t  tm_adr,
    output tile_byte_t  tm_wrt,
    output logic        tm_wen,
    output logic        want_attention  // one-cycle beep request
);

    logic       idle;
    logic       go_trash;
    logic       go_level;
    logic       go_game;
    rand_t      rand_bits;
    logic       score_clear;
    logic       level_inc;
    logic       score_inc;
    logic       digit_read;
    logic       score_wen;
    tile_byte_t score_wrt;

    command_decode u_command_decode (
        .clk            (clk),
        .rst            (rst),
        .cmd            (cmd),
        .idle           (idle),
        .go_trash       (go_trash),
        .go_level       (go_level),
        .go_game        (go_game),
        .want_attention (want_attention)
    );

    prng_pair u_prng_pair (
        .clk       (clk),
        .rst       (rst),
        .rand_bits (rand_bits)
    );

    field_scan u_field_scan (
        .clk         (clk),
        .rst         (rst),
        .go_trash    (go_trash),
        .go_level    (go_level),
        .go_game     (go_game),
        .rand_bits   (rand_bits),
        .score_wen   (score_wen),
        .score_wrt   (score_wrt),
        .idle        (idle),
        .score_clear (score_clear),
        .level_inc   (level_inc),
        .score_inc   (score_inc),
        .digit_read  (digit_read),
        .tm_adr      (tm_adr),
        .tm_wrt      (tm_wrt),
        .tm_wen      (tm_wen)
    );

    score_keeper u_score_keeper (
        .clk         (clk),
        .rst         (rst),
        .score_clear (score_clear),
        .level_inc   (level_inc),
        .score_inc   (score_inc),
        .digit_read  (digit_read),
        .tm_red      (tm_red),
        .score_wen   (score_wen),
        .score_wrt   (score_wrt)
    );

endmodule

// File: hdl/score_keeper.sv
// tag bytes are not rewritten; the digit bytes after a tag in scan order get units first
`include "robots_config.svh"

module score_keeper import robots_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       score_clear,
    input  logic       level_inc,
    input  logic       score_inc,
    input  logic       digit_read,  // tm_red is a score side byte
    input  tile_byte_t tm_red,
    output logic       score_wen,
    output tile_byte_t score_wrt
);

    bcd2_t       level;
    logic [1:0]  level_blank;
    bcd6_t       score;
    logic [5:0]  score_blank;
    bcd6_t       high;
    logic [5:0]  high_blank;
    logic        tag_hit;
    bcd6_t       wr_digits;    // digits still to go, units at bottom
    logic [5:0]  wr_blank;
    logic [2:0]  wr_count;     // bytes left in the current string

    bcd_counter #(.DIGITS(2)) u_level (
        .clk   (clk),
        .rst   (rst),
        .clear (score_clear),
        .inc   (level_inc),
        .value (level),
        .blank (level_blank)
    );

    bcd_counter #(.DIGITS(6)) u_score (
        .clk   (clk),
        .rst   (rst),
        .clear (score_clear),
        .inc   (score_inc),
        .value (score),
        .blank (score_blank)
    );

    // high follows score while they match, no compare-and-copy needed
    bcd_counter #(.DIGITS(6)) u_high (
        .clk   (clk),
        .rst   (rst),
        .clear (1'b0),                      // survives a new game
        .inc   (score_inc && (score == high)),
        .value (high),
        .blank (high_blank)
    );

    assign tag_hit = (tm_red[7:5] == `TAG_LEVEL) || (tm_red[7:5] == `TAG_SCORE) ||
                     (tm_red[7:5] == `TAG_HIGH);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_count <= '0;
        end else if (digit_read) begin
            if (tm_red[7:5] == `TAG_LEVEL)
                wr_count <= 3'd2;
            else if (tag_hit)
                wr_count <= 3'd6;                   // score or high
            else if (wr_count != '0)
                wr_count <= wr_count - 3'd1;
        end
    end

    // string load on a tag, else one digit shift per byte
    always_ff @(posedge clk) begin
        if (digit_read) begin
            case (tm_red[7:5])
                `TAG_LEVEL: begin
                    wr_digits <= {16'd0, level};
                    wr_blank  <= {4'hf, level_blank};
                end
                `TAG_SCORE: begin
                    wr_digits <= score;
                    wr_blank  <= score_blank;
                end
                `TAG_HIGH: begin
                    wr_digits <= high;
                    wr_blank  <= high_blank;
                end
                default: begin
                    wr_digits <= {4'd0, wr_digits[23:4]};
                    wr_blank  <= {1'b1, wr_blank[5:1]};
                end
            endcase
        end
    end

    assign score_wen = digit_read && !tag_hit && (wr_count != '0);
    assign score_wrt = {tm_red[7:4], wr_blank[0] ? `BLANK_DIGIT : wr_digits[3:0]}; // keep glyph bank
endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the robots play engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module robots_play_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/Vrobots_play_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0

// File: verif/robots_play_tb.sv
// needs the tile map model tags in column 127 of pair rows 0-2; a pass is seen as tm_adr reaching byte 0
`include "robots_config.svh"

module robots_play_tb import robots_pkg::*; ();

    localparam int STEPS        = 6;
    localparam int MAP_BYTES    = `MAP_COLS * `MAP_PAIR_ROWS;
    localparam int PASS_TIMEOUT = 40000;             // a pass takes 30720 cycles
    localparam int BEEP_TIMEOUT = 20;
    localparam int LEVEL_UNITS  = `MAP_COLS - 2;     // byte right after each tag
    localparam int SCORE_UNITS  = 2 * `MAP_COLS - 2;
    localparam int HIGH_UNITS   = 3 * `MAP_COLS - 2;

    // cmd strobe, passes to wait, level, score, high, field check
    localparam int STEP_TAB [STEPS][6] = '{
        '{'h0000, 2, 1, 0, 0, 1},  // boot runs new game then first level
        '{'h0400, 1, 1, 1, 1, 0},  // F3 trash, high follows score
        '{'h0400, 1, 1, 2, 2, 0},
        '{'h0100, 1, 2, 2, 2, 1},  // F1 next level
        '{'h0800, 2, 1, 0, 2, 1},  // quit, high kept
        '{'h0200, 0, 1, 0, 2, 0}   // F2 beep, no pass
    };

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] cmd;
    tile_byte_t  tm_red;
    tile_addr_t  tm_adr;
    tile_byte_t  tm_wrt;
    logic        tm_wen;
    logic        want_attention;
    int          wen_count  = 0;   // tile map writes so far
    int          beep_count = 0;   // cycles with want_attention high

    robots_play_top u_robots_play_top (
        .clk            (clk),
        .rst            (rst),
        .cmd            (cmd),
        .tm_red         (tm_red),
        .tm_adr         (tm_adr),
        .tm_wrt         (tm_wrt),
        .tm_wen         (tm_wen),
        .want_attention (want_attention)
    );

    tile_map_model u_tile_map_model (
        .clk (clk),
        .adr (tm_adr),
        .wrt (tm_wrt),
        .wen (tm_wen),
        .red (tm_red)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (tm_wen)
            wen_count <= wen_count + 1;
        if (want_attention)
            beep_count <= beep_count + 1;
    end

    task automatic report_failure(input string text);
        $display("%s", text);
        $display("*** FAILED ***");
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            report_failure($sformatf("MISMATCH at %0t: %s is %0d, expected %0d",
                                     $time, what, got, exp));
            $fatal(1);
        end
    endtask

    // glyph for one digit position, leading zeros hidden except the units
    function automatic int digit_glyph(input int value, input int pos);
        int scale;
        scale = 1;
        for (int k = 0; k < pos; k++)
            scale = scale * 10;
        if (pos > 0 && value < scale)
            return int'(`BLANK_DIGIT);
        return (value / scale) % 10;
    endfunction

    task automatic pulse_cmd(input logic [15:0] bits);
        @(posedge clk);
        cmd <= bits;
        @(posedge clk);
        cmd <= '0;
    endtask

    task automatic wait_passes(input int passes);
        int cycles;
        @(negedge clk);
        for (int p = 0; p < passes; p++) begin
            cycles = 0;
            while (tm_adr != '0 && cycles < PASS_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            assert (cycles < PASS_TIMEOUT) else begin
                report_failure("timeout: scan pass never reached byte 0");
                $fatal(1);
            end
            cycles = 0;
            while (tm_adr == '0 && cycles < 10) begin  // last write lands here
                @(negedge clk);
                cycles++;
            end
            assert (cycles < 10) else begin
                report_failure("timeout: scan stayed on byte 0");
                $fatal(1);
            end
        end
    endtask

    task automatic wait_beep();
        int cycles;
        int start;
        start  = beep_count;
        cycles = 0;
        while (beep_count == start && cycles < BEEP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < BEEP_TIMEOUT) else begin
            report_failure("timeout: want_attention never went high");
            $fatal(1);
        end
    endtask

    task automatic check_digits(input string what, input int units_addr, input int digits,
                                input int value);
        tile_addr_t a;
        for (int pos = 0; pos < digits; pos++) begin
            a = tile_addr_t'(units_addr - pos);   // higher digits sit at lower columns
            check_value($sformatf("%s digit %0d", what, pos), int'(u_tile_map_model.mem[a]),
                        digit_glyph(value, pos));
        end
    endtask

    // play side holds robots and one player only, player row kept within 16-79
    task automatic check_field();
        tile_addr_t a;
        tile_byte_t b;
        int         players;
        int         player_row;
        players    = 0;
        player_row = -1;
        for (int i = 0; i < MAP_BYTES; i++) begin
            a = tile_addr_t'(i);
            if (a[6:3] != `SCORE_COL_MSB) begin
                b = u_tile_map_model.mem[a];
                check_value($sformatf("upper nibble of byte %0d", i), int'(b[7:4]), 0);
                assert (b[1:0] != CELL_TRASH && b[3:2] != CELL_TRASH) else begin
                    report_failure($sformatf("MISMATCH at %0t: trash code in byte %0d",
                                             $time, i));
                    $fatal(1);
                end
                if (b[1:0] == CELL_PLAYER) begin
                    players++;
                    player_row = 2 * int'(a[12:7]);      // upper cell, even row
                end
                if (b[3:2] == CELL_PLAYER) begin
                    players++;
                    player_row = 2 * int'(a[12:7]) + 1;
                end
            end
        end
        check_value("player count", players, 1);
        assert (player_row >= 16 && player_row <= 79) else begin
            report_failure($sformatf("MISMATCH at %0t: player on cell row %0d, outside 16-79",
                                     $time, player_row));
            $fatal(1);
        end
    endtask

    initial begin
        logic [15:0] step_cmd;
        int          wen_start;
        int          beep_start;
        rst = 1'b1;
        cmd = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);                 // boot cycle
        check_value("tm_wen after reset", int'(tm_wen), 0);
        check_value("want_attention after reset", int'(want_attention), 0);
        for (int s = 0; s < STEPS; s++) begin
            step_cmd   = 16'(STEP_TAB[s][0]);
            wen_start  = wen_count;
            beep_start = beep_count;
            if (step_cmd != '0)
                pulse_cmd(step_cmd);
            if (step_cmd[9])
                wait_beep();
            wait_passes(STEP_TAB[s][1]);
            check_digits("level", LEVEL_UNITS, 2, STEP_TAB[s][2]);
            check_digits("score", SCORE_UNITS, 6, STEP_TAB[s][3]);
            check_digits("high", HIGH_UNITS, 6, STEP_TAB[s][4]);
            if (STEP_TAB[s][5] != 0)
                check_field();
            repeat (3) @(negedge clk);  // monitor counts settle
            check_value("want_attention cycles", beep_count - beep_start, step_cmd[9] ? 1 : 0);
            if (STEP_TAB[s][1] == 0)
                check_value("tile map writes", wen_count - wen_start, 0);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verif/tile_map_model.sv
// one cycle read latency; a read during a write to the same byte returns the old value
`include "robots_config.svh"

module tile_map_model import robots_pkg::*; (
    input  logic       clk,
    input  tile_addr_t adr,
    input  tile_byte_t wrt,
    input  logic       wen,
    output tile_byte_t red
);

    localparam int MAP_BYTES = `MAP_COLS * `MAP_PAIR_ROWS;

    tile_byte_t mem [0:MAP_BYTES-1];

    // play side gets address noise; score side digits start at codes 11-15 that no write uses
    initial begin
        tile_addr_t a;
        for (int i = 0; i < MAP_BYTES; i++) begin
            a = tile_addr_t'(i);
            if (a[6:3] == `SCORE_COL_MSB)
                mem[a] = 8'(11 + i % 5);    // upper nibble stays 0
            else
                mem[a] = a[7:0] ^ {a[12:8], 3'b101};
        end
        mem[13'd127] = 8'd160; // level tag in pair row 0
        mem[13'd255] = 8'd192; // score tag in pair row 1
        mem[13'd383] = 8'd224; // high score tag in pair row 2
    end

    always @(posedge clk) begin
        if (wen)
            mem[adr] <= wrt;
        red <= mem[adr];        // byte at last cycle's address
    end

endmodule
